// File: design/lockstep_pkg.sv
`default_nettype none

package lockstep_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Accumulator and operand width
  parameter int unsigned DataW = 16;

  // Operation counter width, the counter wraps
  parameter int unsigned CntW = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_ADD = 2'b00,  // acc + operand
    OP_SUB = 2'b01,  // acc - operand
    OP_XOR = 2'b10,  // acc ^ operand
    OP_CLR = 2'b11   // acc loaded with operand
  } acc_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Core bundles
  ////////////////////////////////////////////////////////////////////////////

  // Input bundle seen by a core in one cycle, valid is a single-cycle strobe
  typedef struct packed {
    logic             valid;
    acc_op_e          op;
    logic [DataW-1:0] operand;
  } core_in_t;

  // Registered output bundle of a core
  // Parity is the XOR reduction of acc
  typedef struct packed {
    logic [DataW-1:0] acc;
    logic [CntW-1:0]  op_count;
    logic             parity;
  } core_out_t;

endpackage

`default_nettype wire

// File: design/acc_core.sv
`timescale 1ns/1ps
`default_nettype none

module acc_core (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire lockstep_pkg::core_in_t  in_i,
  output lockstep_pkg::core_out_t      out_o
);

  lockstep_pkg::core_out_t        out_q;
  logic [lockstep_pkg::DataW-1:0] acc_d;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  // Next accumulator value for the requested operation
  always_comb begin
    case (in_i.op)
      lockstep_pkg::OP_ADD: acc_d = out_q.acc + in_i.operand;
      lockstep_pkg::OP_SUB: acc_d = out_q.acc - in_i.operand;
      lockstep_pkg::OP_XOR: acc_d = out_q.acc ^ in_i.operand;
      lockstep_pkg::OP_CLR: acc_d = in_i.operand;
      default:              acc_d = out_q.acc;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  // Every output field is held in this register, so results show one
  // cycle after the valid input
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q <= '0;
    end else if (in_i.valid) begin
      out_q.acc      <= acc_d;
      out_q.op_count <= out_q.op_count + lockstep_pkg::CntW'(1);
      // Parity follows the new accumulator value
      out_q.parity   <= ^acc_d;
    end
  end

  assign out_o = out_q;

  // Counter only advances on the edge that consumed a valid input
  op_count_on_valid_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$stable(out_o.op_count) |-> $past(in_i.valid)
  );

endmodule

`default_nettype wire

// File: design/shadow_rst_seq.sv
`timescale 1ns/1ps
`default_nettype none

module shadow_rst_seq #(
  parameter int unsigned LockstepOffset = 2
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  output logic      shadow_rst_no,
  output logic      cmp_en_o
);

  // Counter only needs to reach LockstepOffset-1 and then holds
  localparam int unsigned        CntBits = $clog2(LockstepOffset);
  localparam logic [CntBits-1:0] CntLast = CntBits'(LockstepOffset - 1);

  logic [CntBits-1:0] cnt_q;
  logic               release_d;
  logic               release_q;
  logic               cmp_en_q;

  ////////////////////////////////////////////////////////////////////////////
  // Release counter
  ////////////////////////////////////////////////////////////////////////////

  // Starts at zero on reset release and saturates
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_q != CntLast) begin
      cnt_q <= cnt_q + CntBits'(1);
    end
  end

  assign release_d = (cnt_q == CntLast);

  // Shadow reset drops with rst_ni and rises synchronously at the
  // LockstepOffset-th edge; compare enable follows one edge later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      release_q <= 1'b0;
      cmp_en_q  <= 1'b0;
    end else begin
      release_q <= release_d;
      cmp_en_q  <= release_q;
    end
  end

  assign shadow_rst_no = release_q;
  assign cmp_en_o      = cmp_en_q;

  // Comparison may only start once the shadow core has left reset
  cmp_after_release_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(cmp_en_o) |-> $past(shadow_rst_no)
  );

endmodule

`default_nettype wire

// File: design/input_delay.sv
`timescale 1ns/1ps
`default_nettype none

module input_delay #(
  parameter int unsigned LockstepOffset = 2
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire lockstep_pkg::core_in_t in_i,
  output lockstep_pkg::core_in_t      out_o
);

  // Stage 0 is the oldest entry and feeds the shadow core
  lockstep_pkg::core_in_t [LockstepOffset-1:0] stage_q;

  ////////////////////////////////////////////////////////////////////////////
  // Shift register
  ////////////////////////////////////////////////////////////////////////////

  // Cleared to zero so the shadow core sees no valid strobes while
  // the pipeline refills after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      for (int unsigned i = 0; i < LockstepOffset - 1; i++) begin
        stage_q[i] <= stage_q[i+1];
      end
      // New entry goes in at the top
      stage_q[LockstepOffset-1] <= in_i;
    end
  end

  assign out_o = stage_q[0];

  // Output is the input from exactly LockstepOffset cycles ago once
  // the line has been filled since reset
  delay_exact_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni, LockstepOffset) |-> (out_o == $past(in_i, LockstepOffset))
  );

endmodule

`default_nettype wire

// File: design/output_compare.sv
`timescale 1ns/1ps
`default_nettype none

module output_compare #(
  parameter int unsigned LockstepOffset = 2
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    cmp_en_i,
  input  wire lockstep_pkg::core_out_t main_out_i,
  input  wire lockstep_pkg::core_out_t shadow_out_i,
  output logic                         alert_major_o
);

  // One extra stage balances the shadow output register
  localparam int unsigned MainDepth = LockstepOffset + 1;

  lockstep_pkg::core_out_t [MainDepth-1:0] main_q;
  lockstep_pkg::core_out_t                 shadow_q;
  logic                                    mismatch;

  ////////////////////////////////////////////////////////////////////////////
  // Main-core output delay
  ////////////////////////////////////////////////////////////////////////////

  // Several corrupted words can be in flight here at once
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_q <= '0;
    end else begin
      for (int unsigned i = 0; i < MainDepth - 1; i++) begin
        main_q[i] <= main_q[i+1];
      end
      main_q[MainDepth-1] <= main_out_i;
    end
  end

  // Shadow outputs get one register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else begin
      shadow_q <= shadow_out_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////////////////////

  // Any bit of acc, op_count or parity differing counts
  assign mismatch      = (main_q[0] != shadow_q);
  assign alert_major_o = cmp_en_i & mismatch;

  // No alert while the shadow pipeline is still refilling
  no_alert_when_disabled_a : assert property (
    @(posedge clk_i)
    !cmp_en_i |-> !alert_major_o
  );

endmodule

`default_nettype wire

// File: design/lockstep_top.sv
`timescale 1ns/1ps
`default_nettype none

module lockstep_top #(
  parameter int unsigned LockstepOffset = 2
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire lockstep_pkg::core_in_t  core_in_i,
  input  wire lockstep_pkg::core_out_t core_out_i,
  output logic                         alert_major_o
);

  logic                    shadow_rst_n;
  logic                    cmp_en;
  lockstep_pkg::core_in_t  shadow_in;
  lockstep_pkg::core_out_t shadow_out;

  ////////////////////////////////////////////////////////////////////////////
  // Shadow reset and compare enable
  ////////////////////////////////////////////////////////////////////////////

  shadow_rst_seq #(
    .LockstepOffset(LockstepOffset)
  ) u_shadow_rst_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .shadow_rst_no(shadow_rst_n),
    .cmp_en_o     (cmp_en)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Shadow core and its delayed inputs
  ////////////////////////////////////////////////////////////////////////////

  input_delay #(
    .LockstepOffset(LockstepOffset)
  ) u_input_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .in_i  (core_in_i),
    .out_o (shadow_in)
  );

  // Same core as the main one, running LockstepOffset cycles behind
  acc_core u_shadow_core (
    .clk_i (clk_i),
    .rst_ni(shadow_rst_n),
    .in_i  (shadow_in),
    .out_o (shadow_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output comparison
  ////////////////////////////////////////////////////////////////////////////

  output_compare #(
    .LockstepOffset(LockstepOffset)
  ) u_output_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmp_en_i     (cmp_en),
    .main_out_i   (core_out_i),
    .shadow_out_i (shadow_out),
    .alert_major_o(alert_major_o)
  );

endmodule

`default_nettype wire

// File: tb/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int unsigned PeriodNs  = 10,
  parameter int unsigned RstCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // Free-running clock, first rising edge at half a period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2) clk_o = ~clk_o;
    end
  end

  // Power-on reset, released 1 ns after the last reset edge
  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb/tb_lockstep_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lockstep_top;

  localparam int unsigned LockstepOffset = 2;
  // Edges from a corrupted drive cycle to the alert cycle
  localparam int          Lat            = int'(LockstepOffset) + 1;

  localparam int unsigned RstCycles    = 4;
  localparam int unsigned QuietCycles  = 400;
  localparam int unsigned NumSingle    = 12;
  localparam int unsigned NumField     = 8;
  localparam int unsigned SingleGap    = 10;
  localparam int unsigned NumBurst     = 6;
  localparam int unsigned MaxBurst     = 6;
  localparam int unsigned BurstGap     = 12;
  localparam int unsigned RandomCycles = 500;
  localparam int unsigned FaultRate    = 16;
  localparam int unsigned DrainCycles  = LockstepOffset + 5;

  localparam int unsigned PlannedCycles = RstCycles + QuietCycles
      + (NumSingle + 2 * NumField) * (1 + SingleGap)
      + NumBurst * (MaxBurst + BurstGap)
      + 1 + RstCycles + RandomCycles + DrainCycles;
  localparam int unsigned TimeoutCycles = PlannedCycles + 64;

  // Fault kinds
  localparam int unsigned FaultAcc    = 0;
  localparam int unsigned FaultCount  = 1;
  localparam int unsigned FaultParity = 2;
  localparam int unsigned FaultAny    = 3;

  localparam lockstep_pkg::core_out_t NoMask = '0;

  logic                    clk;
  logic                    por_rst_n;
  logic                    soft_rst_n;
  logic                    dut_rst_n;
  lockstep_pkg::core_in_t  core_in;
  lockstep_pkg::core_out_t core_out;
  logic                    alert;

  integer                  seed;
  lockstep_pkg::core_out_t model_q;
  int                      cycle_cnt;
  int                      since_rst;
  int                      fault_q[$];
  int unsigned             check_cnt;
  int unsigned             error_cnt;
  int unsigned             exp_alert_cnt;
  int unsigned             seen_alert_cnt;

  clk_gen #(
    .PeriodNs (10),
    .RstCycles(RstCycles)
  ) u_clk_gen (
    .clk_o (clk),
    .rst_no(por_rst_n)
  );

  // Mid-run resets are layered on top of the power-on reset
  assign dut_rst_n = por_rst_n & soft_rst_n;

  lockstep_top #(
    .LockstepOffset(LockstepOffset)
  ) UUT (
    .clk_i        (clk),
    .rst_ni       (dut_rst_n),
    .core_in_i    (core_in),
    .core_out_i   (core_out),
    .alert_major_o(alert)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Main-core model and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic lockstep_pkg::core_out_t model_next(
    input lockstep_pkg::core_out_t cur,
    input lockstep_pkg::core_in_t  stim
  );
    lockstep_pkg::core_out_t        nxt;
    logic [lockstep_pkg::DataW-1:0] acc;
    nxt = cur;
    if (stim.valid) begin
      case (stim.op)
        lockstep_pkg::OP_ADD: acc = cur.acc + stim.operand;
        lockstep_pkg::OP_SUB: acc = cur.acc - stim.operand;
        lockstep_pkg::OP_XOR: acc = cur.acc ^ stim.operand;
        default:              acc = stim.operand;
      endcase
      nxt.acc      = acc;
      nxt.op_count = cur.op_count + lockstep_pkg::CntW'(1);
      nxt.parity   = ^acc;
    end
    return nxt;
  endfunction

  function automatic lockstep_pkg::core_in_t rand_input();
    lockstep_pkg::core_in_t stim;
    logic [31:0]            r;
    r = $random(seed);
    // Roughly three cycles out of four carry a valid strobe
    stim.valid   = (r[1:0] != 2'b00);
    stim.op      = lockstep_pkg::acc_op_e'(r[3:2]);
    stim.operand = r[lockstep_pkg::DataW+3:4];
    return stim;
  endfunction

  // Nonzero XOR mask confined to one field, or spread over the whole bundle
  function automatic lockstep_pkg::core_out_t fault_mask(input int unsigned kind);
    lockstep_pkg::core_out_t m;
    logic [31:0]             r;
    r = $random(seed);
    m = '0;
    case (kind)
      FaultAcc: begin
        m.acc = r[lockstep_pkg::DataW-1:0];
        if (m.acc == '0) m.acc = lockstep_pkg::DataW'(1);
      end
      FaultCount: begin
        m.op_count = r[lockstep_pkg::CntW-1:0];
        if (m.op_count == '0) m.op_count = lockstep_pkg::CntW'(1);
      end
      FaultParity: m.parity = 1'b1;
      default: begin
        m = r[$bits(lockstep_pkg::core_out_t)-1:0];
        if (m == '0) m.parity = 1'b1;
      end
    endcase
    return m;
  endfunction

  task automatic check_value(
    input string       name,
    input logic [31:0] actual,
    input logic [31:0] expected
  );
    check_cnt++;
    if (actual !== expected) begin
      error_cnt++;
      $display("ERROR at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // One clock cycle: update the model, check the alert, then drive the next inputs
  task automatic step_cycle(
    input logic                    hold_rst,
    input logic                    corrupt,
    input lockstep_pkg::core_out_t mask
  );
    logic hit;
    logic exp_alert;
    @(posedge clk);
    cycle_cnt++;
    if (!dut_rst_n) begin
      since_rst = 0;
      model_q   = '0;
    end else begin
      since_rst++;
      model_q = model_next(model_q, core_in);
    end
    #1;
    // Faults older than the compare point are gone
    while (fault_q.size() > 0 && fault_q[0] < cycle_cnt - Lat) begin
      void'(fault_q.pop_front());
    end
    hit = (fault_q.size() > 0) && (fault_q[0] == cycle_cnt - Lat);
    // Compare enable is high once Lat edges have passed since reset release
    exp_alert = hit && (since_rst >= Lat);
    check_value("alert_major_o", {31'b0, alert}, {31'b0, exp_alert});
    if (exp_alert) exp_alert_cnt++;
    if (alert === 1'b1) seen_alert_cnt++;
    // Main core resets asynchronously together with the DUT
    soft_rst_n = !hold_rst;
    if (hold_rst) model_q = '0;
    core_in  = rand_input();
    core_out = model_q;
    if (corrupt) begin
      core_out = model_q ^ mask;
      fault_q.push_back(cycle_cnt);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int unsigned i;
    int unsigned j;
    int unsigned blen;
    logic [31:0] r;
    seed           = 57;
    core_in        = '0;
    core_out       = '0;
    soft_rst_n     = 1'b1;
    model_q        = '0;
    cycle_cnt      = 0;
    since_rst      = 0;
    check_cnt      = 0;
    error_cnt      = 0;
    exp_alert_cnt  = 0;
    seen_alert_cnt = 0;

    // Faults that are sampled while still in reset must be ignored
    for (i = 0; i < RstCycles - 1; i++) step_cycle(1'b0, 1'b1, fault_mask(FaultAny));
    step_cycle(1'b0, 1'b0, NoMask);

    // Long clean traffic
    for (i = 0; i < QuietCycles; i++) step_cycle(1'b0, 1'b0, NoMask);

    // Single-cycle accumulator faults
    for (i = 0; i < NumSingle; i++) begin
      step_cycle(1'b0, 1'b1, fault_mask(FaultAcc));
      repeat (SingleGap) step_cycle(1'b0, 1'b0, NoMask);
    end

    // Counter only, then parity only
    for (i = 0; i < NumField; i++) begin
      step_cycle(1'b0, 1'b1, fault_mask(FaultCount));
      repeat (SingleGap) step_cycle(1'b0, 1'b0, NoMask);
    end
    for (i = 0; i < NumField; i++) begin
      step_cycle(1'b0, 1'b1, fault_mask(FaultParity));
      repeat (SingleGap) step_cycle(1'b0, 1'b0, NoMask);
    end

    // Bursts keep several faulty words in the delay line at once
    for (i = 0; i < NumBurst; i++) begin
      r    = $random(seed);
      blen = 2 + (r % (MaxBurst - 1));
      for (j = 0; j < blen; j++) step_cycle(1'b0, 1'b1, fault_mask(FaultAny));
      for (j = blen; j < MaxBurst + BurstGap; j++) step_cycle(1'b0, 1'b0, NoMask);
    end

    // Mid-run reset with a fault in flight and faults during reset
    step_cycle(1'b0, 1'b1, fault_mask(FaultAny));
    for (i = 0; i < RstCycles; i++) step_cycle(1'b1, 1'b1, fault_mask(FaultAny));

    // Random faults after the restart
    for (i = 0; i < RandomCycles; i++) begin
      r = $random(seed);
      step_cycle(1'b0, (r % FaultRate) == 0, fault_mask(FaultAny));
    end
    for (i = 0; i < DrainCycles; i++) step_cycle(1'b0, 1'b0, NoMask);

    if (exp_alert_cnt == 0) begin
      error_cnt++;
      $display("No alert was expected during the run, so fault detection was never exercised");
    end
    $display("Checks: %0d, errors: %0d, alerts expected: %0d, alerts seen: %0d",
             check_cnt, error_cnt, exp_alert_cnt, seen_alert_cnt);
    if (error_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int unsigned n;
    n = 0;
    while (n < TimeoutCycles) begin
      @(posedge clk);
      n++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
design/lockstep_pkg.sv
design/acc_core.sv
design/shadow_rst_seq.sv
design/input_delay.sv
design/output_compare.sv
design/lockstep_top.sv
tb/clk_gen.sv
tb/tb_lockstep_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the lockstep checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_lockstep_top \
  -f src.f

out=$(./obj_dir/Vtb_lockstep_top)
echo "$out"

if echo "$out" | grep -qx 'TEST RESULT: PASS'; then
  exit 0
else
  exit 1
fi
